// File: filelist.f
+incdir+source
source/core_pkg.sv
source/heartbeat_led.sv
source/frame_fifo.sv
source/loopback_core.sv
bench/loopback_core_tb.sv

// File: Bender.yml
package:
  name: loopback_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/heartbeat_led.sv
      - source/frame_fifo.sv
      - source/loopback_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/loopback_core_tb.sv

// File: bench/loopback_core_tb.sv
// Loopback core testbench

`resetall
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module loopback_core_tb;

localparam int HB_COUNT = 20;
localparam int DEPTH = `CORE_FIFO_DEPTH;
localparam int TIMEOUT = 20000;

logic                 clk_125mhz = 1'b0;
logic                 rst_125mhz;
logic                 link_up[2];
core_pkg::axis_beat_t rx_beat[2];
logic                 rx_valid[2];
logic                 rx_ready[2];
core_pkg::axis_beat_t tx_beat[2];
logic                 tx_valid[2];
logic                 tx_ready[2];
logic                 frame_good[2];
logic                 frame_bad[2];
logic                 sfp_led[2];
logic                 led_hb;

integer seed = 32'h49e6_ac6e;

// Selects tx_ready as held high (0), held low (1) or random (2)
int   tx_mode;
logic rst_prev;

// Expected transmit beats per channel
core_pkg::axis_beat_t exp_q0[$];
core_pkg::axis_beat_t exp_q1[$];
int exp_good[2];
int exp_bad[2];
int got_good[2];
int got_bad[2];

// Previous transmit state for the hold check
core_pkg::axis_beat_t tx_prev[2];
logic                 tx_stall[2];

always #4 clk_125mhz = !clk_125mhz;

loopback_core #(
    .HB_COUNT(HB_COUNT)
)
uut (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .link_up(link_up),
    .rx_beat(rx_beat),
    .rx_valid(rx_valid),
    .rx_ready(rx_ready),
    .tx_beat(tx_beat),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .frame_good(frame_good),
    .frame_bad(frame_bad),
    .sfp_led(sfp_led),
    .led_hb(led_hb)
);

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    if (expected !== actual) begin
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end
endtask

// Sends one frame and queues it in the model when it should commit
task automatic send_frame(input int ch, input int len, input bit bad, input bit expect_good);
    core_pkg::axis_beat_t beat;
    integer r;
    int waited;
    for (int i = 0; i < len; i++) begin
        r = $random(seed);
        beat.data = {$random(seed), $random(seed)};
        beat.keep = r[`CORE_KEEP_W-1:0];
        beat.last = (i == len - 1);
        beat.user = bad && beat.last;
        if (expect_good && ch == 0) exp_q0.push_back(beat);
        if (expect_good && ch == 1) exp_q1.push_back(beat);
        rx_beat[ch] = beat;
        rx_valid[ch] = 1'b1;
        waited = 0;
        @(posedge clk_125mhz);
        while (!rx_ready[ch]) begin
            if (waited >= TIMEOUT) begin
                stop_with_error($sformatf("Receive ready never came on channel %0d", ch));
            end
            waited++;
            @(posedge clk_125mhz);
        end
        #1;
    end
    rx_valid[ch] = 1'b0;
    if (expect_good) exp_good[ch]++;
    else exp_bad[ch]++;
endtask

task automatic random_frames(input int ch, input int count, input bit with_bad);
    int len;
    bit bad;
    for (int f = 0; f < count; f++) begin
        len = 1 + ({$random(seed)} % 40);
        bad = with_bad && (({$random(seed)} % 4) == 0);
        send_frame(ch, len, bad, !bad);
        // Idle gap of up to two cycles between frames
        repeat ({$random(seed)} % 3) begin
            @(posedge clk_125mhz);
            #1;
        end
    end
endtask

// Fills one channel with tx_ready low until a few frames overflow
task automatic fill_channel(input int ch);
    int committed = 0;
    int drops = 0;
    int len;
    bit fits;
    for (int iter = 0; drops < 3; iter++) begin
        if (iter > 500) stop_with_error($sformatf("FIFO on channel %0d never filled", ch));
        len = 1 + ({$random(seed)} % 40);
        fits = (len <= DEPTH - committed);
        if (fits) committed += len;
        else drops++;
        send_frame(ch, len, 1'b0, fits);
    end
endtask

task automatic wait_drain(input string what);
    int waited = 0;
    while (exp_q0.size() != 0 || exp_q1.size() != 0 ||
           got_good[0] != exp_good[0] || got_good[1] != exp_good[1] ||
           got_bad[0] != exp_bad[0] || got_bad[1] != exp_bad[1]) begin
        if (waited >= TIMEOUT) stop_with_error({"Timed out waiting for ", what});
        waited++;
        @(posedge clk_125mhz);
    end
    // Late pulses would show up as extra counts
    repeat (4) @(posedge clk_125mhz);
    #1;
    for (int n = 0; n < 2; n++) begin
        check_value($sformatf("%s frame_good count ch%0d", what, n), exp_good[n], got_good[n]);
        check_value($sformatf("%s frame_bad count ch%0d", what, n), exp_bad[n], got_bad[n]);
    end
endtask

task automatic check_heartbeat();
    logic prev;
    int count;
    int waited = 0;
    @(posedge clk_125mhz);
    prev = led_hb;
    while (led_hb === prev) begin
        if (waited >= 100) stop_with_error("Heartbeat LED never changed level");
        waited++;
        @(posedge clk_125mhz);
    end
    for (int k = 0; k < 4; k++) begin
        prev = led_hb;
        count = 0;
        do begin
            @(posedge clk_125mhz);
            count++;
            if (count > 100) stop_with_error("Heartbeat LED stuck at one level");
        end while (led_hb === prev);
        check_value("heartbeat period", HB_COUNT + 1, count);
    end
endtask

// Link and tx_ready stimulus
always @(posedge clk_125mhz) begin
    integer r;
    #1;
    for (int n = 0; n < 2; n++) begin
        r = $random(seed);
        link_up[n] = r[0];
        tx_ready[n] = (tx_mode == 0) ? 1'b1 : (tx_mode == 1) ? 1'b0 : r[1];
    end
end

// Output monitor and model compare
always @(posedge clk_125mhz) begin
    core_pkg::axis_beat_t exp_beat;
    if (!rst_125mhz && !rst_prev) begin
        for (int n = 0; n < 2; n++) begin
            check_value($sformatf("link LED ch%0d", n), !link_up[n], sfp_led[n]);
            check_value($sformatf("receive ready ch%0d", n), 1'b1, rx_ready[n]);
            if (frame_good[n]) got_good[n]++;
            if (frame_bad[n]) got_bad[n]++;
            if (tx_stall[n]) begin
                check_value($sformatf("held tx_valid ch%0d", n), 1'b1, tx_valid[n]);
                check_value($sformatf("held tx_beat ch%0d", n), tx_prev[n], tx_beat[n]);
            end
            if (tx_valid[n] && tx_ready[n]) begin
                if ((n == 0 && exp_q0.size() == 0) || (n == 1 && exp_q1.size() == 0)) begin
                    stop_with_error($sformatf("Unexpected transmit beat on channel %0d", n));
                end
                exp_beat = (n == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check_value($sformatf("loopback beat ch%0d", n), exp_beat, tx_beat[n]);
            end
            tx_stall[n] = tx_valid[n] && !tx_ready[n];
            tx_prev[n] = tx_beat[n];
        end
    end
    rst_prev = rst_125mhz;
end

initial begin
    rst_125mhz = 1'b1;
    rst_prev = 1'b1;
    tx_mode = 0;
    for (int n = 0; n < 2; n++) begin
        link_up[n] = 1'b0;
        rx_beat[n] = '0;
        rx_valid[n] = 1'b0;
        tx_ready[n] = 1'b1;
        tx_stall[n] = 1'b0;
        exp_good[n] = 0;
        exp_bad[n] = 0;
        got_good[n] = 0;
        got_bad[n] = 0;
    end

    repeat (2) @(posedge clk_125mhz);
    #1;
    check_value("heartbeat LED in reset", 1'b1, led_hb);
    for (int n = 0; n < 2; n++) begin
        check_value($sformatf("tx_valid in reset ch%0d", n), 1'b0, tx_valid[n]);
        check_value($sformatf("frame_good in reset ch%0d", n), 1'b0, frame_good[n]);
        check_value($sformatf("frame_bad in reset ch%0d", n), 1'b0, frame_bad[n]);
    end
    rst_125mhz = 1'b0;

    // Good frames on both channels with the heartbeat measured alongside
    fork
        check_heartbeat();
        random_frames(0, 40, 1'b0);
        random_frames(1, 40, 1'b0);
    join
    wait_drain("good frames");

    // Mix of good and bad frames
    fork
        random_frames(0, 40, 1'b1);
        random_frames(1, 40, 1'b1);
    join
    wait_drain("mixed good and bad frames");

    // Output stalled until the FIFOs overflow
    tx_mode = 1;
    repeat (2) @(posedge clk_125mhz);
    #1;
    fork
        fill_channel(0);
        fill_channel(1);
    join
    tx_mode = 0;
    wait_drain("frames held in the full FIFO");

    // Random back-pressure
    tx_mode = 2;
    fork
        random_frames(0, 60, 1'b1);
        random_frames(1, 60, 1'b1);
    join
    wait_drain("frames under back-pressure");

    $display("TEST RESULT: PASS");
    $finish;
end

endmodule

`resetall

// File: source/loopback_core.sv
// Two-channel frame loopback core

`resetall
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module loopback_core #(
    // Heartbeat reload value
    parameter int HB_COUNT = `CORE_HB_COUNT
) (
    // 125 MHz clock and synchronous reset
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_125mhz,

    // Link status per channel
    input  wire logic                 link_up[2],

    // Receive streams
    input  wire core_pkg::axis_beat_t rx_beat[2],
    input  wire logic                 rx_valid[2],
    output wire logic                 rx_ready[2],

    // Transmit streams
    output wire core_pkg::axis_beat_t tx_beat[2],
    output wire logic                 tx_valid[2],
    input  wire logic                 tx_ready[2],

    // Frame status pulses
    output wire logic                 frame_good[2],
    output wire logic                 frame_bad[2],

    // LEDs, all active low
    output wire logic                 sfp_led[2],
    output wire logic                 led_hb
);

heartbeat_led #(
    .HB_COUNT(HB_COUNT)
)
hb_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .led_hb(led_hb)
);

for (genvar n = 0; n < 2; n = n + 1) begin : ch

    // Link LED lit while the link is up
    assign sfp_led[n] = !link_up[n];

    // Receive frames are stored whole, then looped back out
    frame_fifo #(
        .DEPTH(`CORE_FIFO_DEPTH)
    )
    fifo_inst (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),

        // Sink
        .s_beat(rx_beat[n]),
        .s_valid(rx_valid[n]),
        .s_ready(rx_ready[n]),

        // Source
        .m_beat(tx_beat[n]),
        .m_valid(tx_valid[n]),
        .m_ready(tx_ready[n]),

        // Status
        .frame_good(frame_good[n]),
        .frame_bad(frame_bad[n])
    );

end

endmodule

`resetall

// File: source/frame_fifo.sv
// Single-clock frame FIFO

`resetall
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module frame_fifo #(
    // Depth in beats, power of two
    parameter int DEPTH = `CORE_FIFO_DEPTH
) (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_125mhz,

    // Sink, fed by the receive stream
    input  wire core_pkg::axis_beat_t s_beat,
    input  wire logic                 s_valid,
    output logic                      s_ready,

    // Source, drives the transmit stream
    output core_pkg::axis_beat_t      m_beat,
    output logic                      m_valid,
    input  wire logic                 m_ready,

    // One-cycle frame status pulses
    output logic                      frame_good,
    output logic                      frame_bad
);

localparam int ADDR_W = $clog2(DEPTH);

// Fill levels at which no further beat fits
localparam logic [ADDR_W:0] FILL_FULL = (ADDR_W + 1)'(DEPTH);
localparam logic [ADDR_W:0] FILL_FULL_OUT = (ADDR_W + 1)'(DEPTH - 1);

// Beat storage
core_pkg::axis_beat_t mem [DEPTH];

// Speculative write, last commit point and read position
core_pkg::fifo_ptr_t wr_ptr;
core_pkg::fifo_ptr_t commit_ptr;
core_pkg::fifo_ptr_t rd_ptr;

// Set while the rest of an overflowed frame is thrown away
logic drop_frame;

logic [ADDR_W:0] fill;
logic            full;
logic            s_xfer;
logic            store;
logic            rd_avail;
logic            rd_load;

// Beats held in RAM, written but not yet read
assign fill = wr_ptr[ADDR_W:0] - rd_ptr[ADDR_W:0];

// A beat waiting in the output register still takes one slot
assign full = (fill == FILL_FULL) || (m_valid && fill == FILL_FULL_OUT);

assign s_xfer = s_valid && s_ready;
assign store = s_xfer && !drop_frame && !full;

// Write side

always_ff @(posedge clk_125mhz) begin
    if (store) begin
        mem[wr_ptr[ADDR_W-1:0]] <= s_beat;
    end
end

always_ff @(posedge clk_125mhz) begin
    frame_good <= 1'b0;
    frame_bad <= 1'b0;

    // Never back-pressured, full frames are dropped instead
    s_ready <= 1'b1;

    if (s_xfer) begin
        if (store) begin
            wr_ptr <= wr_ptr + 1'b1;

            if (s_beat.last) begin
                if (s_beat.user) begin
                    // Bad frame, forget everything since the commit point
                    wr_ptr <= commit_ptr;
                    frame_bad <= 1'b1;
                end else begin
                    // Frame complete, hand it to the read side
                    commit_ptr <= wr_ptr + 1'b1;
                    frame_good <= 1'b1;
                end
            end
        end else begin
            // Overflow or already dropping
            wr_ptr <= commit_ptr;
            drop_frame <= !s_beat.last;
            frame_bad <= s_beat.last;
        end
    end

    if (rst_125mhz) begin
        s_ready <= 1'b0;
        wr_ptr <= '0;
        commit_ptr <= '0;
        drop_frame <= 1'b0;
        frame_good <= 1'b0;
        frame_bad <= 1'b0;
    end
end

// Read side

// Only committed beats are visible here
assign rd_avail = commit_ptr[ADDR_W:0] != rd_ptr[ADDR_W:0];

// Refill when the output register is empty or being emptied
assign rd_load = rd_avail && (!m_valid || m_ready);

always_ff @(posedge clk_125mhz) begin
    if (rd_load) begin
        m_beat <= mem[rd_ptr[ADDR_W-1:0]];
    end
end

always_ff @(posedge clk_125mhz) begin
    if (rd_load) begin
        rd_ptr <= rd_ptr + 1'b1;
        m_valid <= 1'b1;
    end else if (m_ready) begin
        m_valid <= 1'b0;
    end

    if (rst_125mhz) begin
        rd_ptr <= '0;
        m_valid <= 1'b0;
    end
end

endmodule

`resetall

// File: source/heartbeat_led.sv
// Heartbeat LED blinker

`resetall
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module heartbeat_led #(
    // Reload value, the LED toggles every HB_COUNT+1 cycles
    parameter int HB_COUNT = `CORE_HB_COUNT
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,

    // Active low heartbeat LED
    output wire logic led_hb
);

localparam int CNT_W = $clog2(HB_COUNT + 1);

logic [CNT_W-1:0] hb_cnt;
logic             hb_bit;

// LED is lit while the bit is high
assign led_hb = !hb_bit;

always_ff @(posedge clk_125mhz) begin
    if (hb_cnt == '0) begin
        hb_cnt <= CNT_W'(HB_COUNT);
        hb_bit <= !hb_bit;
    end else begin
        hb_cnt <= hb_cnt - 1'b1;
    end

    // Zero count makes the first toggle come right after reset
    if (rst_125mhz) begin
        hb_cnt <= '0;
        hb_bit <= 1'b0;
    end
end

endmodule

`resetall

// File: source/core_pkg.sv
// Loopback core types

`include "core_settings.svh"

package core_pkg;

// Address bits of the frame FIFO RAM
localparam int FIFO_ADDR_W = $clog2(`CORE_FIFO_DEPTH);

// One beat of the receive or transmit stream
typedef struct packed {
    // Payload word
    logic [`CORE_DATA_W-1:0] data;
    // Byte enables, bit 0 covers data[7:0]
    logic [`CORE_KEEP_W-1:0] keep;
    // Final beat of the frame
    logic                    last;
    // Bad frame flag, only looked at together with last
    logic                    user;
} axis_beat_t;

// RAM address with the wrap bit on top
typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

endpackage

// File: source/core_settings.svh
// Loopback core settings

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Stream word width in bits, one 64-bit word per beat
`define CORE_DATA_W 64

// One byte enable per data byte
`define CORE_KEEP_W (`CORE_DATA_W / 8)

// Frame FIFO depth in beats
// Must be a power of two
`define CORE_FIFO_DEPTH 2048

// Heartbeat reload value
// About 0.5 s per half period at 125 MHz
`define CORE_HB_COUNT 62500000

`endif
